// ==== design/crc32_gen.sv ====
module crc32_gen import eth_tx_pkg::*;
(
   input  logic        clk_i,
   input  logic        reset_i,
   input  logic        clear_i,
   input  logic        update_i,
   input  logic [7:0]  data_i,
   output logic [31:0] fcs_o
);

   logic [31:0] crc_q;

   // Shift one byte LSB first through the reflected register
   function automatic logic [31:0] crc_byte(input logic [31:0] crc, input logic [7:0] data);
      logic [31:0] c;
      c = crc ^ {24'd0, data};
      for (int i = 0; i < 8; i++)
      begin
         c = c[0] ? ((c >> 1) ^ CRC_POLY) : (c >> 1);
      end
      return c;
   endfunction

   always_ff @(posedge clk_i)
   begin
      if (reset_i)
      begin
         crc_q <= CRC_INIT;
      end
      else if (clear_i)
      begin
         crc_q <= CRC_INIT;
      end
      else if (update_i)
      begin
         crc_q <= crc_byte(crc_q, data_i);
      end
   end

   assign fcs_o = crc_q ^ CRC_RESIDUE_XOR;   // Byte 0 goes out first

endmodule

// ==== design/eth_tx_pkg.sv ====
package eth_tx_pkg;

   // Wire framing
   localparam logic [7:0] PREAMBLE_BYTE = 8'h55;
   localparam logic [7:0] SFD_BYTE      = 8'hd5;
   localparam int PREAMBLE_LEN  = 7;
   localparam int MIN_FRAME_LEN = 60;   // Before FCS
   localparam int FCS_LEN       = 4;
   localparam int IFG_LEN       = 12;   // Idle cycles between frames

   // Frame buffer geometry
   localparam int BUF_DEPTH = 2048;
   localparam int BUF_AW    = 11;

   // IEEE 802.3 CRC-32 in reflected form
   localparam logic [31:0] CRC_POLY        = 32'hedb88320;
   localparam logic [31:0] CRC_INIT        = 32'hffffffff;
   localparam logic [31:0] CRC_RESIDUE_XOR = 32'hffffffff;

   // Framer counter widths
   localparam int STEP_W     = $clog2(IFG_LEN);
   localparam int BYTE_CNT_W = $clog2(MIN_FRAME_LEN + 1);

   typedef struct packed {
      logic [7:0] data;
      logic       last;   // Final payload byte
      logic       bad;    // Valid with last
   } fb_byte_t;

   typedef struct packed {
      logic [7:0] txd;
      logic       tx_en;
      logic       tx_er;
   } gmii_tx_t;

   typedef struct packed {
      logic [15:0] frames_good;
      logic [15:0] frames_bad;
   } tx_stats_t;

endpackage

// ==== design/frame_buffer.sv ====
module frame_buffer import eth_tx_pkg::*;
(
   input  logic     clk_i,
   input  logic     reset_i,
   input  logic     wr_i,
   input  fb_byte_t wr_data_i,
   output logic     full_o,
   input  logic     rd_i,
   output fb_byte_t rd_data_o,
   output logic     frame_avail_o
);

   fb_byte_t          mem [BUF_DEPTH];
   logic [BUF_AW-1:0] wr_ptr;
   logic [BUF_AW-1:0] rd_ptr;
   logic [BUF_AW:0]   fill_cnt;
   logic [BUF_AW:0]   frame_cnt;   // Complete frames not yet read
   logic              wr_ok;
   logic              rd_ok;
   logic              wr_eof;
   logic              rd_eof;

   assign wr_ok  = wr_i && !full_o;   // Writes while full are dropped
   assign rd_ok  = rd_i && (fill_cnt != '0);
   assign wr_eof = wr_ok && wr_data_i.last;
   assign rd_eof = rd_ok && rd_data_o.last;

   always_ff @(posedge clk_i)
   begin
      if (wr_ok)
      begin
         mem[wr_ptr] <= wr_data_i;
      end
   end

   // Head of buffer with no read latency
   assign rd_data_o = mem[rd_ptr];

   always_ff @(posedge clk_i)
   begin
      if (reset_i)
      begin
         wr_ptr    <= '0;
         rd_ptr    <= '0;
         fill_cnt  <= '0;
         frame_cnt <= '0;
      end
      else
      begin
         if (wr_ok)
         begin
            wr_ptr <= wr_ptr + 1'b1;
         end
         if (rd_ok)
         begin
            rd_ptr <= rd_ptr + 1'b1;
         end

         case ({wr_ok, rd_ok})
            2'b10:   fill_cnt <= fill_cnt + 1'b1;
            2'b01:   fill_cnt <= fill_cnt - 1'b1;
            default: fill_cnt <= fill_cnt;
         endcase

         // Frame written and frame consumed in one cycle cancel
         case ({wr_eof, rd_eof})
            2'b10:   frame_cnt <= frame_cnt + 1'b1;
            2'b01:   frame_cnt <= frame_cnt - 1'b1;
            default: frame_cnt <= frame_cnt;
         endcase
      end
   end

   assign full_o        = (fill_cnt == (BUF_AW + 1)'(BUF_DEPTH));
   assign frame_avail_o = (frame_cnt != '0);

endmodule

// ==== design/gmii_tx_framer.sv ====
module gmii_tx_framer import eth_tx_pkg::*;
(
   input  logic     clk_i,
   input  logic     reset_i,
   input  logic     frame_avail_i,
   output logic     rd_o,
   input  fb_byte_t rd_data_i,
   output gmii_tx_t gmii_o,
   output logic     frame_done_o,
   output logic     frame_bad_o
);

   typedef enum logic [2:0] {
      S_IDLE,
      S_PREAMBLE,
      S_SFD,
      S_PAYLOAD,
      S_PAD,
      S_FCS,
      S_GAP
   } state_t;

   state_t                state_q;
   state_t                state_d;
   logic [STEP_W-1:0]     step_q;       // Preamble, FCS and gap position
   logic [STEP_W-1:0]     step_d;
   logic [BYTE_CNT_W-1:0] byte_cnt_q;   // Bytes sent up to MIN_FRAME_LEN
   logic [BYTE_CNT_W-1:0] byte_cnt_d;
   logic                  bad_q;
   logic                  bad_d;
   logic                  done_q;
   logic                  done_d;
   gmii_tx_t              gmii_q;
   gmii_tx_t              gmii_d;
   logic                  crc_clear;
   logic                  crc_update;
   logic [7:0]            crc_data;
   logic [31:0]           fcs;

   crc32_gen crc32_gen_i (
      .clk_i    (clk_i),
      .reset_i  (reset_i),
      .clear_i  (crc_clear),
      .update_i (crc_update),
      .data_i   (crc_data),
      .fcs_o    (fcs)
   );

   always_comb
   begin
      state_d    = state_q;
      step_d     = step_q;
      byte_cnt_d = byte_cnt_q;
      bad_d      = bad_q;
      done_d     = 1'b0;
      gmii_d     = '0;
      rd_o       = 1'b0;
      crc_clear  = 1'b0;
      crc_update = 1'b0;
      crc_data   = 8'h00;

      case (state_q)
         S_IDLE:
         begin
            if (frame_avail_i)   // Whole frame already stored
            begin
               state_d = S_PREAMBLE;
               step_d  = '0;
            end
         end
         S_PREAMBLE:
         begin
            gmii_d.txd   = PREAMBLE_BYTE;
            gmii_d.tx_en = 1'b1;
            crc_clear    = 1'b1;
            step_d       = step_q + 1'b1;
            if (step_q == STEP_W'(PREAMBLE_LEN - 1))
            begin
               state_d = S_SFD;
            end
         end
         S_SFD:
         begin
            gmii_d.txd   = SFD_BYTE;
            gmii_d.tx_en = 1'b1;
            byte_cnt_d   = '0;
            state_d      = S_PAYLOAD;
         end
         S_PAYLOAD:
         begin
            gmii_d.txd   = rd_data_i.data;
            gmii_d.tx_en = 1'b1;
            rd_o         = 1'b1;
            crc_update   = 1'b1;
            crc_data     = rd_data_i.data;
            if (byte_cnt_q != BYTE_CNT_W'(MIN_FRAME_LEN))
            begin
               byte_cnt_d = byte_cnt_q + 1'b1;
            end
            if (rd_data_i.last)
            begin
               bad_d  = rd_data_i.bad;
               step_d = '0;
               // Short frame still needs zero fill
               state_d = (byte_cnt_q < BYTE_CNT_W'(MIN_FRAME_LEN - 1)) ? S_PAD : S_FCS;
            end
         end
         S_PAD:
         begin
            gmii_d.tx_en = 1'b1;   // txd stays zero
            crc_update   = 1'b1;
            byte_cnt_d   = byte_cnt_q + 1'b1;
            if (byte_cnt_q == BYTE_CNT_W'(MIN_FRAME_LEN - 1))
            begin
               state_d = S_FCS;
               step_d  = '0;
            end
         end
         S_FCS:
         begin
            gmii_d.txd   = fcs[{step_q[1:0], 3'b000} +: 8];
            gmii_d.tx_en = 1'b1;
            gmii_d.tx_er = bad_q;   // PHY corrupts a bad frame
            step_d       = step_q + 1'b1;
            if (step_q == STEP_W'(FCS_LEN - 1))
            begin
               state_d = S_GAP;
               step_d  = '0;
               done_d  = 1'b1;
            end
         end
         S_GAP:
         begin
            step_d = step_q + 1'b1;
            if (step_q == STEP_W'(IFG_LEN - 1))
            begin
               state_d = S_IDLE;
            end
         end
         default: state_d = S_IDLE;
      endcase
   end

   always_ff @(posedge clk_i)
   begin
      if (reset_i)
      begin
         state_q    <= S_IDLE;
         step_q     <= '0;
         byte_cnt_q <= '0;
         bad_q      <= 1'b0;
         done_q     <= 1'b0;
         gmii_q     <= '0;
      end
      else
      begin
         state_q    <= state_d;
         step_q     <= step_d;
         byte_cnt_q <= byte_cnt_d;
         bad_q      <= bad_d;
         done_q     <= done_d;
         gmii_q     <= gmii_d;   // Single output register for all GMII lines
      end
   end

   assign gmii_o       = gmii_q;
   assign frame_done_o = done_q;
   assign frame_bad_o  = bad_q;

endmodule

// ==== design/gmii_tx_top.sv ====
module gmii_tx_top import eth_tx_pkg::*;
(
   input  logic      GMII_GTX_CLK_int,
   input  logic      reset_i,
   input  logic      wr_i,
   input  fb_byte_t  wr_data_i,
   output logic      full_o,
   output gmii_tx_t  gmii_o,
   output tx_stats_t stats_o
);

   logic     fb_rd;
   fb_byte_t fb_rd_data;
   logic     frame_avail;
   logic     frame_done;
   logic     frame_bad;

   frame_buffer frame_buffer_i (
      .clk_i         (GMII_GTX_CLK_int),
      .reset_i       (reset_i),
      .wr_i          (wr_i),
      .wr_data_i     (wr_data_i),
      .full_o        (full_o),
      .rd_i          (fb_rd),
      .rd_data_o     (fb_rd_data),
      .frame_avail_o (frame_avail)
   );

   gmii_tx_framer gmii_tx_framer_i (
      .clk_i         (GMII_GTX_CLK_int),
      .reset_i       (reset_i),
      .frame_avail_i (frame_avail),
      .rd_o          (fb_rd),
      .rd_data_i     (fb_rd_data),
      .gmii_o        (gmii_o),        // Already registered
      .frame_done_o  (frame_done),
      .frame_bad_o   (frame_bad)
   );

   tx_stats tx_stats_i (
      .clk_i        (GMII_GTX_CLK_int),
      .reset_i      (reset_i),
      .frame_done_i (frame_done),
      .frame_bad_i  (frame_bad),
      .stats_o      (stats_o)
   );

endmodule

// ==== design/tx_stats.sv ====
module tx_stats import eth_tx_pkg::*;
(
   input  logic      clk_i,
   input  logic      reset_i,
   input  logic      frame_done_i,
   input  logic      frame_bad_i,
   output tx_stats_t stats_o
);

   always_ff @(posedge clk_i)
   begin
      if (reset_i)
      begin
         stats_o <= '0;
      end
      else if (frame_done_i)
      begin
         if (frame_bad_i)
         begin
            if (stats_o.frames_bad != '1)   // Hold at max
            begin
               stats_o.frames_bad <= stats_o.frames_bad + 1'b1;
            end
         end
         else
         begin
            if (stats_o.frames_good != '1)
            begin
               stats_o.frames_good <= stats_o.frames_good + 1'b1;
            end
         end
      end
   end

endmodule

// ==== gmii_tx_top.f ====
design/eth_tx_pkg.sv
design/crc32_gen.sv
design/frame_buffer.sv
design/gmii_tx_framer.sv
design/tx_stats.sv
design/gmii_tx_top.sv
verification/gmii_tx_checker.sv
verification/gmii_tx_tb.sv

// ==== verification/gmii_tx_checker.sv ====
module gmii_tx_checker import eth_tx_pkg::*;
(
   input logic     clk_i,
   input logic     reset_i,
   input gmii_tx_t gmii_i
);

   timeunit 1ns;
   timeprecision 1ps;

   int fail_cnt = 0;   // Assertion failures so far

   // Error only inside a frame
   er_needs_en: assert property (@(posedge clk_i) disable iff (reset_i)
      gmii_i.tx_er |-> gmii_i.tx_en)
   else
   begin
      $error("tx_er high while tx_en low");
      fail_cnt++;
   end

   idle_after_reset: assert property (@(posedge clk_i)
      $fell(reset_i) |-> !gmii_i.tx_en)
   else
   begin
      $error("tx_en high right after reset");
      fail_cnt++;
   end

   // Inter-frame gap
   min_gap: assert property (@(posedge clk_i) disable iff (reset_i)
      $fell(gmii_i.tx_en) |-> !gmii_i.tx_en [*IFG_LEN])
   else
   begin
      $error("inter-frame gap shorter than IFG_LEN");
      fail_cnt++;
   end

   preamble_first: assert property (@(posedge clk_i) disable iff (reset_i)
      $rose(gmii_i.tx_en) |-> gmii_i.txd == PREAMBLE_BYTE)
   else
   begin
      $error("frame does not open with a preamble byte");
      fail_cnt++;
   end

endmodule

bind gmii_tx_framer gmii_tx_checker gmii_tx_checker_i (
   .clk_i   (clk_i),
   .reset_i (reset_i),
   .gmii_i  (gmii_o)
);

// ==== verification/gmii_tx_tb.sv ====
module gmii_tx_tb import eth_tx_pkg::*;
();

   timeunit 1ns;
   timeprecision 1ps;

   localparam int CLK_PERIOD    = 8;
   localparam int MAX_RAND_LEN  = 200;
   localparam int NUM_FRAMES    = 16;
   localparam int PAYLOAD_BOUND = 100 + 10 + 4 * MAX_RAND_LEN + 64 + 30 + 5 * MAX_RAND_LEN
                                  + (BUF_DEPTH - 4) + 40 + 20;
   localparam int FRAME_EXTRA   = PREAMBLE_LEN + 1 + MIN_FRAME_LEN + FCS_LEN + IFG_LEN + 2;
   // Write and wire time doubled plus a margin
   localparam int RUN_CYCLES    = 2 * (2 * PAYLOAD_BOUND + NUM_FRAMES * FRAME_EXTRA) + 2000;

   logic      GMII_GTX_CLK_int;
   logic      reset;
   logic      wr;
   fb_byte_t  wr_data;
   logic      full;
   gmii_tx_t  gmii;
   tx_stats_t stats;

   integer    seed;
   gmii_tx_t  exp_q[$];       // Expected wire cycles of all frames in order
   int        exp_len_q[$];   // Expected tx_en burst lengths
   int        exp_good = 0;
   int        exp_bad = 0;
   int        burst_len = 0;
   int        idle_len = IFG_LEN;
   int        frames_seen = 0;
   logic      saw_full = 1'b0;

   gmii_tx_top gmii_tx_top_i (
      .GMII_GTX_CLK_int (GMII_GTX_CLK_int),
      .reset_i          (reset),
      .wr_i             (wr),
      .wr_data_i        (wr_data),
      .full_o           (full),
      .gmii_o           (gmii),
      .stats_o          (stats)
   );

   initial
   begin
      GMII_GTX_CLK_int = 1'b0;
      forever #(CLK_PERIOD / 2) GMII_GTX_CLK_int = ~GMII_GTX_CLK_int;
   end

   task automatic report_error(input string msg);
      $display("[ERROR] %0t %s", $time, msg);
      $display(">>> FAIL");
      $fatal(1, "stopped at first mismatch");
   endtask

   task automatic compare_gmii(input gmii_tx_t act, input gmii_tx_t exp, input string what);
      if (act !== exp)
         report_error($sformatf("%s: txd %h en %b er %b, expected txd %h en %b er %b", what,
                                act.txd, act.tx_en, act.tx_er, exp.txd, exp.tx_en, exp.tx_er));
   endtask

   task automatic compare_stats(input tx_stats_t act, input tx_stats_t exp);
      if (act !== exp)
         report_error($sformatf("stats good %0d bad %0d, expected good %0d bad %0d",
                                act.frames_good, act.frames_bad, exp.frames_good, exp.frames_bad));
   endtask

   // Bit-serial CRC-32 over the reflected 04C11DB7 polynomial
   function automatic logic [31:0] crc32_ref(input logic [7:0] data[$]);
      logic [31:0] crc;
      crc = 32'hffffffff;
      foreach (data[i])
      begin
         for (int b = 0; b < 8; b++)
            crc = (crc[0] ^ data[i][b]) ? ((crc >> 1) ^ 32'hedb88320) : (crc >> 1);
      end
      return ~crc;
   endfunction

   function automatic gmii_tx_t wire_byte(input logic [7:0] d, input logic er);
      gmii_tx_t w;
      w.txd   = d;
      w.tx_en = 1'b1;
      w.tx_er = er;
      return w;
   endfunction

   task automatic put_byte(input fb_byte_t b);
      @(posedge GMII_GTX_CLK_int);
      #1;
      while (full)   // Hold off until the framer frees a slot
      begin
         wr       = 1'b0;
         saw_full = 1'b1;
         @(posedge GMII_GTX_CLK_int);
         #1;
      end
      wr      = 1'b1;
      wr_data = b;
   endtask

   task automatic send_frame(input int len, input logic bad);
      logic [7:0]  payload[$];
      logic [7:0]  body[$];
      logic [31:0] fcs;
      fb_byte_t    b;
      for (int i = 0; i < len; i++)
         payload.push_back(8'($random(seed)));
      body = payload;
      while (body.size() < MIN_FRAME_LEN)
         body.push_back(8'h00);   // Zero pad
      fcs = crc32_ref(body);
      repeat (PREAMBLE_LEN) exp_q.push_back(wire_byte(PREAMBLE_BYTE, 1'b0));
      exp_q.push_back(wire_byte(SFD_BYTE, 1'b0));
      foreach (body[i])
         exp_q.push_back(wire_byte(body[i], 1'b0));
      for (int i = 0; i < FCS_LEN; i++)
         exp_q.push_back(wire_byte(fcs[8 * i +: 8], bad));   // LSB first
      exp_len_q.push_back(PREAMBLE_LEN + 1 + body.size() + FCS_LEN);
      if (bad)
         exp_bad++;
      else
         exp_good++;
      for (int i = 0; i < len; i++)
      begin
         b.data = payload[i];
         b.last = (i == len - 1);
         b.bad  = bad && (i == len - 1);
         put_byte(b);
      end
      @(posedge GMII_GTX_CLK_int);
      #1;
      wr = 1'b0;
   endtask

   task automatic wait_drained();
      while (exp_q.size() != 0 || burst_len != 0)
         @(negedge GMII_GTX_CLK_int);
      repeat (IFG_LEN + 2) @(negedge GMII_GTX_CLK_int);   // Let stats settle
   endtask

   task automatic test_long_frame();
      send_frame(100, 1'b0);
      wait_drained();
   endtask

   task automatic test_short_pad();
      send_frame(10, 1'b0);
      wait_drained();
   endtask

   task automatic test_back_to_back();
      repeat (4) send_frame(1 + ($unsigned($random(seed)) % MAX_RAND_LEN), 1'b0);
      wait_drained();
   endtask

   task automatic test_bad_frame();
      send_frame(64, 1'b1);
      send_frame(30, 1'b0);
      wait_drained();
   endtask

   task automatic test_stats_count();
      tx_stats_t exp;
      repeat (5) send_frame(1 + ($unsigned($random(seed)) % MAX_RAND_LEN), $random(seed) & 1);
      wait_drained();
      exp.frames_good = 16'(exp_good);
      exp.frames_bad  = 16'(exp_bad);
      compare_stats(stats, exp);
   endtask

   task automatic test_fill_buffer();
      saw_full = 1'b0;
      send_frame(BUF_DEPTH - 4, 1'b0);   // Nothing drains until this one is complete
      send_frame(40, 1'b0);
      send_frame(20, 1'b1);
      wait_drained();
      if (!saw_full)
         report_error("buffer never reported full while frames were queued");
   endtask

   // Wire monitor samples away from the active edge
   always @(negedge GMII_GTX_CLK_int)
   begin
      if (!reset)
      begin
         if (gmii.tx_en)
         begin
            if (burst_len == 0 && frames_seen > 0 && idle_len < IFG_LEN)
               report_error($sformatf("only %0d idle cycles between frames", idle_len));
            if (exp_q.size() == 0)
               report_error("tx_en high with no frame expected");
            compare_gmii(gmii, exp_q.pop_front(), "wire cycle");
            burst_len++;
            idle_len = 0;
         end
         else
         begin
            compare_gmii(gmii, '0, "idle wire");
            if (burst_len != 0)
            begin
               if (exp_len_q.size() == 0 || burst_len != exp_len_q.pop_front())
                  report_error($sformatf("tx_en burst of %0d cycles was unexpected", burst_len));
               frames_seen++;
               burst_len = 0;
            end
            idle_len++;
         end
      end
   end

   // Stop at the first protocol assertion failure in the bound checker
   always @(negedge GMII_GTX_CLK_int)
   begin
      if (gmii_tx_top_i.gmii_tx_framer_i.gmii_tx_checker_i.fail_cnt != 0)
      begin
         $display("A GMII protocol assertion failed");
         $display(">>> FAIL");
         $fatal(1, "assertion failure");
      end
   end

   initial
   begin
      #(RUN_CYCLES * CLK_PERIOD);
      $display("Timeout: frames were still outstanding after %0d cycles", RUN_CYCLES);
      $display(">>> FAIL");
      $fatal(1, "watchdog expired");
   end

   initial
   begin
      logic [7:0] check_str[$];
      seed    = 32'hd45d;
      reset   = 1'b1;
      wr      = 1'b0;
      wr_data = '0;
      repeat (10) @(posedge GMII_GTX_CLK_int);
      #1;
      reset = 1'b0;
      @(negedge GMII_GTX_CLK_int);
      compare_gmii(gmii, '0, "after reset");
      compare_stats(stats, '0);
      // Reference CRC against the standard check value
      check_str = '{8'h31, 8'h32, 8'h33, 8'h34, 8'h35, 8'h36, 8'h37, 8'h38, 8'h39};
      if (crc32_ref(check_str) !== 32'hcbf43926)
         report_error("reference CRC-32 disagrees with the standard check value");
      test_long_frame();
      test_short_pad();
      test_back_to_back();
      test_bad_frame();
      test_stats_count();
      test_fill_buffer();
      if (gmii_tx_top_i.gmii_tx_framer_i.gmii_tx_checker_i.fail_cnt == 0)
      begin
         $display(">>> PASS");
         $finish;
      end
      else
      begin
         $display("GMII protocol assertions failed during the run");
         $display(">>> FAIL");
         $fatal(1, "assertion failures");
      end
   end

endmodule
